//--- filelist.f
+incdir+sim
rtl/lc4_pkg.sv
rtl/lc4_regfile.sv
rtl/lc4_decoder.sv
rtl/lc4_alu.sv
rtl/lc4_hazard_unit.sv
rtl/lc4_branch_unit.sv
rtl/lc4_processor.sv
sim/lc4_sva.sv
sim/tb_lc4.sv

//--- rtl/lc4_alu.sv
module lc4_alu
   import lc4_pkg::*;
(
   input  alu_op_e i_alu_op,
   input  word_t   i_insn,
   input  word_t   i_pc,
   input  word_t   i_a,
   input  word_t   i_b,
   output word_t   o_result
);

   word_t imm5;
   word_t imm6;
   word_t imm9;

   // Sign-extended immediate fields
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      case (i_alu_op)
         ALU_ADD:      o_result = i_a + i_b;
         ALU_ADDI:     o_result = i_a + imm5;
         ALU_AND:      o_result = i_a & i_b;
         ALU_ANDI:     o_result = i_a & imm5;
         ALU_OR:       o_result = i_a | i_b;
         ALU_XOR:      o_result = i_a ^ i_b;
         ALU_NOT:      o_result = ~i_a;
         ALU_CONST:    o_result = imm9;
         ALU_MEMADDR:  o_result = i_a + imm6;           // LDR and STR address
         ALU_BRTARGET: o_result = i_pc + 16'd1 + imm9;  // Taken target
         default:      o_result = '0;
      endcase
   end

endmodule

//--- rtl/lc4_branch_unit.sv
module lc4_branch_unit
   import lc4_pkg::*;
(
   input  logic  gwe,
   input  logic  i_reset,
   input  logic  i_valid,
   input  word_t i_insn,
   input  word_t i_wdata,
   input  logic  i_nzp_we,
   input  word_t i_target,
   output nzp_t  o_nzp,
   output logic  o_redirect,
   output word_t o_redirect_pc
);

   nzp_t nzp_q;   // Codes of the last writer

   // Codes of the value now in writeback
   assign o_nzp = i_wdata[15]     ? 3'b100 :
                  (i_wdata == '0) ? 3'b010 :
                                    3'b001;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_q <= 3'b000;          // No branch taken before first write
      end else if (i_valid && i_nzp_we) begin
         nzp_q <= o_nzp;
      end
   end

   // Non-branches arrive with a zero mask
   assign o_redirect    = i_valid & (|(i_insn[11:9] & nzp_q));
   assign o_redirect_pc = i_target;

endmodule

//--- rtl/lc4_decoder.sv
module lc4_decoder
   import lc4_pkg::*;
(
   input  word_t    i_insn,
   output reg_idx_t o_rs,
   output reg_idx_t o_rt,
   output reg_idx_t o_rd,
   output logic     o_rs_used,
   output logic     o_rt_used,
   output logic     o_regfile_we,
   output logic     o_nzp_we,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_is_branch,
   output alu_op_e  o_alu_op
);

   opcode_e op;
   logic    imm_form;   // Bit 5 picks the imm5 forms

   assign op       = opcode_e'(i_insn[15:12]);
   assign imm_form = i_insn[5];

   assign o_rs = i_insn[8:6];
   assign o_rd = i_insn[11:9];
   assign o_rt = (op == OP_STR) ? i_insn[11:9] : i_insn[2:0];  // Store data in 11:9

   always_comb begin
      // Defaults give a NOP
      o_rs_used    = 1'b0;
      o_rt_used    = 1'b0;
      o_regfile_we = 1'b0;
      o_nzp_we     = 1'b0;
      o_is_load    = 1'b0;
      o_is_store   = 1'b0;
      o_is_branch  = 1'b0;
      o_alu_op     = ALU_BRTARGET;
      case (op)
         OP_BR: begin
            o_is_branch = 1'b1;         // Mask tested at writeback
         end
         OP_ARITH: begin
            // Only ADD and its immediate form
            if (imm_form || i_insn[5:3] == 3'b000) begin
               o_alu_op     = imm_form ? ALU_ADDI : ALU_ADD;
               o_rs_used    = 1'b1;
               o_rt_used    = ~imm_form;
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
            end
         end
         OP_LOGIC: begin
            o_rs_used    = 1'b1;
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
            if (imm_form) begin
               o_alu_op = ALU_ANDI;
            end else begin
               case (i_insn[4:3])
                  2'b00:   o_alu_op = ALU_AND;
                  2'b01:   o_alu_op = ALU_NOT;
                  2'b10:   o_alu_op = ALU_OR;
                  default: o_alu_op = ALU_XOR;
               endcase
               o_rt_used = (i_insn[4:3] != 2'b01);   // NOT reads Rs only
            end
         end
         OP_LDR: begin
            o_alu_op     = ALU_MEMADDR;
            o_rs_used    = 1'b1;
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
            o_is_load    = 1'b1;
         end
         OP_STR: begin
            o_alu_op   = ALU_MEMADDR;
            o_rs_used  = 1'b1;
            o_rt_used  = 1'b1;
            o_is_store = 1'b1;
         end
         OP_CONST: begin
            o_alu_op     = ALU_CONST;
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
         end
         default: begin
            o_alu_op = ALU_BRTARGET;   // Unknown opcode, nothing enabled
         end
      endcase
   end

endmodule

//--- rtl/lc4_hazard_unit.sv
module lc4_hazard_unit
   import lc4_pkg::*;
(
   input  reg_idx_t i_d_rs,
   input  reg_idx_t i_d_rt,
   input  logic     i_d_rs_used,
   input  logic     i_d_rt_used,
   input  logic     i_d_is_store,
   input  reg_idx_t i_x_rs,
   input  reg_idx_t i_x_rt,
   input  logic     i_x_is_store,
   input  reg_idx_t i_x_rd,
   input  logic     i_x_we,
   input  logic     i_x_is_load,
   input  reg_idx_t i_m_rd,
   input  logic     i_m_we,
   input  logic     i_m_is_load,
   input  reg_idx_t i_m_rt,
   input  logic     i_m_is_store,
   input  reg_idx_t i_w_rd,
   input  logic     i_w_we,
   output logic     o_stall,
   output byp_sel_e o_byp_a,
   output byp_sel_e o_byp_b,
   output logic     o_byp_store
);

   logic mx_a;
   logic mx_b;
   logic wx_a;
   logic wx_b;
   logic ld_to_st;
   logic dep_rs;
   logic dep_rt;

   // ******************************************************************
   // Bypass selects
   // ******************************************************************

   // A load in M holds only its address, the store behind it waits for WM
   assign ld_to_st = i_x_is_store & i_m_is_load;

   assign mx_a = i_m_we & ~i_m_is_load & (i_m_rd == i_x_rs);
   assign mx_b = i_m_we & ~ld_to_st & (i_m_rd == i_x_rt);
   assign wx_a = i_w_we & (i_w_rd == i_x_rs);
   assign wx_b = i_w_we & (i_w_rd == i_x_rt);

   // Younger producer wins
   assign o_byp_a = mx_a ? BYP_MX : (wx_a ? BYP_WX : BYP_REG);
   assign o_byp_b = mx_b ? BYP_MX : (wx_b ? BYP_WX : BYP_REG);

   assign o_byp_store = i_m_is_store & i_w_we & (i_w_rd == i_m_rt);   // WM

   // ******************************************************************
   // Load-use
   // ******************************************************************
   assign dep_rs = i_d_rs_used & (i_d_rs == i_x_rd);
   assign dep_rt = i_d_rt_used & ~i_d_is_store & (i_d_rt == i_x_rd);  // Store data skips

   assign o_stall = i_x_is_load & i_x_we & (dep_rs | dep_rt);

endmodule

//--- rtl/lc4_pkg.sv
package lc4_pkg;

   localparam int WORD_W = 16;
   localparam int REG_W  = 3;

   typedef logic [WORD_W-1:0] word_t;     // Data word or address
   typedef logic [REG_W-1:0]  reg_idx_t;  // R0 to R7
   typedef logic [2:0]        nzp_t;      // Negative, zero, positive

   // Instruction bits 15:12, only the kept classes
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_ADDI,
      ALU_AND,
      ALU_ANDI,
      ALU_OR,
      ALU_XOR,
      ALU_NOT,
      ALU_CONST,
      ALU_MEMADDR,    // Base plus imm6
      ALU_BRTARGET    // PC+1 plus imm9
   } alu_op_e;

   // Execute operand sources
   typedef enum logic [1:0] {
      BYP_REG = 2'd0,   // Value read in decode
      BYP_MX  = 2'd1,   // Result sitting in memory stage
      BYP_WX  = 2'd2    // Value being written back
   } byp_sel_e;

   // BR with mask 000, never taken
   localparam word_t NOP_INSN = 16'h0000;

endpackage

//--- rtl/lc4_processor.sv
module lc4_processor
   import lc4_pkg::*;
#(
   parameter word_t RESET_PC = 16'h8200
) (
   input  logic     gwe,
   input  logic     i_reset,
   output word_t    o_imem_addr,
   input  word_t    i_imem_data,
   output word_t    o_dmem_addr,
   input  word_t    i_dmem_data,
   output word_t    o_dmem_wdata,
   output logic     o_dmem_we,
   output logic     o_trace_valid,
   output word_t    o_trace_pc,
   output word_t    o_trace_insn,
   output logic     o_trace_regfile_we,
   output reg_idx_t o_trace_regfile_reg,
   output word_t    o_trace_regfile_data,
   output logic     o_trace_nzp_we,
   output nzp_t     o_trace_nzp,
   output logic     o_trace_dmem_we,
   output word_t    o_trace_dmem_addr,
   output word_t    o_trace_dmem_value
);

   logic     stall;
   logic     redirect;
   word_t    redirect_pc;
   logic     flush;        // Squash D, M and W inputs
   logic     x_kill;       // Bubble into execute
   byp_sel_e byp_a;
   byp_sel_e byp_b;
   logic     byp_store;

   word_t    pc;

   logic     d_valid;
   word_t    d_insn, d_pc, d_rs_data, d_rt_data;
   reg_idx_t d_rs, d_rt, d_rd;
   logic     d_rs_used, d_rt_used, d_we, d_nzp_we;
   logic     d_is_load, d_is_store, d_is_branch;
   alu_op_e  d_alu_op;

   logic     x_valid, x_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
   word_t    x_insn, x_pc, x_a, x_b;
   reg_idx_t x_rs, x_rt, x_rd;
   alu_op_e  x_alu_op;
   word_t    alu_a, alu_b, alu_result;

   logic     m_valid, m_we, m_nzp_we, m_is_load, m_is_store, m_is_branch;
   word_t    m_insn, m_pc, m_result, m_b, m_mem_value;
   reg_idx_t m_rd, m_rt;

   logic     w_valid, w_we, w_nzp_we, w_is_load, w_is_store, w_is_branch;
   word_t    w_insn, w_pc, w_result, w_dmem_addr, w_mem_value;
   reg_idx_t w_rd;
   word_t    w_wdata, w_br_insn;
   nzp_t     w_nzp;

   // Operand pick for the execute inputs
   function automatic word_t bypass(input byp_sel_e sel, input word_t reg_val,
                                    input word_t mx_val, input word_t wx_val);
      case (sel)
         BYP_MX:  return mx_val;
         BYP_WX:  return wx_val;
         default: return reg_val;
      endcase
   endfunction

   assign flush  = i_reset | redirect;
   assign x_kill = flush | stall;

   // *********************************************************************
   // Fetch, always predicts fall-through
   // *********************************************************************
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc <= RESET_PC;
      end else if (redirect) begin
         pc <= redirect_pc;        // Taken branch at writeback
      end else if (!stall) begin
         pc <= pc + 16'd1;
      end
   end

   assign o_imem_addr = pc;

   always_ff @(posedge gwe) begin
      if (flush) begin
         d_valid <= 1'b0;
         d_insn  <= NOP_INSN;
      end else if (!stall) begin   // Hold on load-use
         d_valid <= 1'b1;
         d_insn  <= i_imem_data;
         d_pc    <= pc;
      end
   end

   // *********************************************************************
   // Decode
   // *********************************************************************
   lc4_decoder u_decoder (
      .i_insn       (d_insn),
      .o_rs         (d_rs),
      .o_rt         (d_rt),
      .o_rd         (d_rd),
      .o_rs_used    (d_rs_used),
      .o_rt_used    (d_rt_used),
      .o_regfile_we (d_we),
      .o_nzp_we     (d_nzp_we),
      .o_is_load    (d_is_load),
      .o_is_store   (d_is_store),
      .o_is_branch  (d_is_branch),
      .o_alu_op     (d_alu_op)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs      (d_rs),
      .i_rt      (d_rt),
      .i_we      (w_we),
      .i_rd      (w_rd),
      .i_wdata   (w_wdata),
      .o_rs_data (d_rs_data),
      .o_rt_data (d_rt_data)
   );

   lc4_hazard_unit u_hazard (
      .i_d_rs       (d_rs),
      .i_d_rt       (d_rt),
      .i_d_rs_used  (d_rs_used),
      .i_d_rt_used  (d_rt_used),
      .i_d_is_store (d_is_store),
      .i_x_rs       (x_rs),
      .i_x_rt       (x_rt),
      .i_x_is_store (x_is_store),
      .i_x_rd       (x_rd),
      .i_x_we       (x_we),
      .i_x_is_load  (x_is_load),
      .i_m_rd       (m_rd),
      .i_m_we       (m_we),
      .i_m_is_load  (m_is_load),
      .i_m_rt       (m_rt),
      .i_m_is_store (m_is_store),
      .i_w_rd       (w_rd),
      .i_w_we       (w_we),
      .o_stall      (stall),
      .o_byp_a      (byp_a),
      .o_byp_b      (byp_b),
      .o_byp_store  (byp_store)
   );

   // *********************************************************************
   // Pipeline latches, control bits cleared on bubble
   // *********************************************************************
   always_ff @(posedge gwe) begin
      x_valid     <= d_valid & ~x_kill;
      x_insn      <= x_kill ? NOP_INSN : d_insn;
      x_we        <= d_we & ~x_kill;
      x_nzp_we    <= d_nzp_we & ~x_kill;
      x_is_load   <= d_is_load & ~x_kill;
      x_is_store  <= d_is_store & ~x_kill;
      x_is_branch <= d_is_branch & ~x_kill;
      x_alu_op    <= x_kill ? ALU_BRTARGET : d_alu_op;

      m_valid     <= x_valid & ~flush;
      m_insn      <= flush ? NOP_INSN : x_insn;
      m_we        <= x_we & ~flush;
      m_nzp_we    <= x_nzp_we & ~flush;
      m_is_load   <= x_is_load & ~flush;
      m_is_store  <= x_is_store & ~flush;
      m_is_branch <= x_is_branch & ~flush;

      w_valid     <= m_valid & ~flush;       // Memory stage squashed too
      w_insn      <= flush ? NOP_INSN : m_insn;
      w_we        <= m_we & ~flush;
      w_nzp_we    <= m_nzp_we & ~flush;
      w_is_load   <= m_is_load & ~flush;
      w_is_store  <= m_is_store & ~flush;
      w_is_branch <= m_is_branch & ~flush;
   end

   // Payload
   always_ff @(posedge gwe) begin
      x_pc        <= d_pc;
      x_rs        <= d_rs;
      x_rt        <= d_rt;
      x_rd        <= d_rd;
      x_a         <= d_rs_data;
      x_b         <= d_rt_data;
      m_pc        <= x_pc;
      m_rd        <= x_rd;
      m_rt        <= x_rt;
      m_result    <= alu_result;
      m_b         <= alu_b;            // Store data after MX/WX
      w_pc        <= m_pc;
      w_rd        <= m_rd;
      w_result    <= m_result;
      w_dmem_addr <= o_dmem_addr;
      w_mem_value <= m_mem_value;
   end

   // *********************************************************************
   // Execute
   // *********************************************************************
   assign alu_a = bypass(byp_a, x_a, m_result, w_wdata);
   assign alu_b = bypass(byp_b, x_b, m_result, w_wdata);

   lc4_alu u_alu (
      .i_alu_op (x_alu_op),
      .i_insn   (x_insn),
      .i_pc     (x_pc),
      .i_a      (alu_a),
      .i_b      (alu_b),
      .o_result (alu_result)
   );

   // *********************************************************************
   // Memory
   // *********************************************************************
   assign o_dmem_addr  = (m_is_load || m_is_store) ? m_result : '0;
   assign o_dmem_wdata = byp_store ? w_wdata : m_b;           // WM bypass
   assign o_dmem_we    = m_valid & m_is_store & ~redirect;    // No write when squashed

   // Loaded or stored value for the trace
   assign m_mem_value = m_is_load  ? i_dmem_data  :
                        m_is_store ? o_dmem_wdata : '0;

   // *********************************************************************
   // Writeback
   // *********************************************************************
   assign w_wdata   = w_is_load ? w_mem_value : w_result;
   assign w_br_insn = w_is_branch ? w_insn : NOP_INSN;       // Zero mask otherwise

   lc4_branch_unit u_branch (
      .gwe           (gwe),
      .i_reset       (i_reset),
      .i_valid       (w_valid),
      .i_insn        (w_br_insn),
      .i_wdata       (w_wdata),
      .i_nzp_we      (w_nzp_we),
      .i_target      (w_result),           // ALU formed PC+1+imm9
      .o_nzp         (w_nzp),
      .o_redirect    (redirect),
      .o_redirect_pc (redirect_pc)
   );

   // Trace of the retiring instruction
   assign o_trace_valid        = w_valid;
   assign o_trace_pc           = w_pc;
   assign o_trace_insn         = w_insn;
   assign o_trace_regfile_we   = w_we;
   assign o_trace_regfile_reg  = w_we ? w_rd : '0;
   assign o_trace_regfile_data = w_we ? w_wdata : '0;
   assign o_trace_nzp_we       = w_nzp_we;
   assign o_trace_nzp          = w_nzp_we ? w_nzp : '0;
   assign o_trace_dmem_we      = w_is_store;
   assign o_trace_dmem_addr    = w_dmem_addr;
   assign o_trace_dmem_value   = w_mem_value;

endmodule

//--- rtl/lc4_regfile.sv
module lc4_regfile
   import lc4_pkg::*;
(
   input  logic     gwe,
   input  logic     i_reset,
   input  reg_idx_t i_rs,
   input  reg_idx_t i_rt,
   input  logic     i_we,
   input  reg_idx_t i_rd,
   input  word_t    i_wdata,
   output word_t    o_rs_data,
   output word_t    o_rt_data
);

   word_t regs [8];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Write-through to the read ports, acts as WD bypass
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_lc4 \
   --Mdir obj_dir -o sim_lc4

./obj_dir/sim_lc4 > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "Failure reported, see sim.log"
   exit 1
fi
echo "No failure reported"

//--- sim/lc4_sva.sv
module lc4_sva (
   input logic gwe,
   input logic i_reset,
   input logic i_m_valid,
   input logic i_m_is_store,
   input logic i_redirect,
   input logic i_dmem_we,
   input logic i_trace_valid
);

   // Latches come out of reset empty
   a_quiet_after_reset: assert property (@(posedge gwe)
      i_reset |=> !i_dmem_we && !i_trace_valid)
      else $error("dmem write or trace valid in the cycle after reset");

   // Store flag gates dmem_we, so it must die with the slot's valid bit
   a_store_valid: assert property (@(posedge gwe) disable iff (i_reset)
      i_m_is_store |-> i_m_valid)
      else $error("store flag set in an invalid memory stage");

   // Four squashed slots, then the target retires
   a_squash_gap: assert property (@(posedge gwe) disable iff (i_reset)
      ($past(i_redirect, 1) || $past(i_redirect, 2) ||
       $past(i_redirect, 3) || $past(i_redirect, 4)) |-> !i_trace_valid)
      else $error("trace valid inside the squash window");

   a_target_retires: assert property (@(posedge gwe) disable iff (i_reset)
      $past(i_redirect, 5) |-> i_trace_valid)
      else $error("branch target not retired five cycles after redirect");

endmodule

bind lc4_processor lc4_sva u_sva (
   .gwe           (gwe),
   .i_reset       (i_reset),
   .i_m_valid     (m_valid),
   .i_m_is_store  (m_is_store),
   .i_redirect    (redirect),
   .i_dmem_we     (o_dmem_we),
   .i_trace_valid (o_trace_valid)
);

//--- sim/lc4_isa_model.svh
`ifndef LC4_ISA_MODEL_SVH
`define LC4_ISA_MODEL_SVH

// **********************************************************************
// Instruction-level reference, one instruction per call
// **********************************************************************

word_t    ref_regs [8];
nzp_t     ref_nzp;               // Clear until first writer
word_t    ref_pc;
word_t    ref_mem [word_t];      // Own copy of data memory

// Expected trace record of the retiring instruction
word_t    exp_pc;
word_t    exp_insn;
logic     exp_rf_we;
reg_idx_t exp_rf_reg;
word_t    exp_rf_data;
logic     exp_nzp_we;
nzp_t     exp_nzp;
logic     exp_dm_we;
word_t    exp_dm_addr;
word_t    exp_dm_value;

function automatic nzp_t nzp_of(input word_t v);
   if (v[15]) begin
      return 3'b100;
   end
   if (v == 16'd0) begin
      return 3'b010;
   end
   return 3'b001;
endfunction

task automatic init_model();
   for (int i = 0; i < 8; i++) begin
      ref_regs[i] = 16'd0;
   end
   ref_nzp = 3'b000;
   ref_pc  = RESET_PC;
   ref_mem.delete();
endtask

// Every register writer also sets NZP
task automatic commit_reg(input reg_idx_t rd, input word_t v);
   ref_regs[rd] = v;
   ref_nzp      = nzp_of(v);
   exp_rf_we    = 1'b1;
   exp_rf_reg   = rd;
   exp_rf_data  = v;
   exp_nzp_we   = 1'b1;
   exp_nzp      = ref_nzp;
endtask

task automatic execute_insn();
   word_t insn;
   word_t a;
   word_t b;
   word_t addr;
   word_t next_pc;
   insn         = fetch_word(ref_pc);
   a            = ref_regs[insn[8:6]];
   b            = ref_regs[insn[2:0]];
   addr         = a + {{10{insn[5]}}, insn[5:0]};   // Base plus imm6
   next_pc      = ref_pc + 16'd1;
   exp_pc       = ref_pc;
   exp_insn     = insn;
   exp_rf_we    = 1'b0;
   exp_rf_reg   = 3'd0;
   exp_rf_data  = 16'd0;
   exp_nzp_we   = 1'b0;
   exp_nzp      = 3'b000;
   exp_dm_we    = 1'b0;
   exp_dm_addr  = 16'd0;
   exp_dm_value = 16'd0;
   case (insn[15:12])
      OP_BR: begin
         if ((insn[11:9] & ref_nzp) != 3'b000) begin
            next_pc = ref_pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
         end
      end
      OP_ARITH: begin
         if (insn[5]) begin
            commit_reg(insn[11:9], a + {{11{insn[4]}}, insn[4:0]});
         end else if (insn[5:3] == 3'b000) begin
            commit_reg(insn[11:9], a + b);
         end
      end
      OP_LOGIC: begin
         if (insn[5]) begin
            commit_reg(insn[11:9], a & {{11{insn[4]}}, insn[4:0]});
         end else begin
            case (insn[4:3])
               2'b00:   commit_reg(insn[11:9], a & b);
               2'b01:   commit_reg(insn[11:9], ~a);
               2'b10:   commit_reg(insn[11:9], a | b);
               default: commit_reg(insn[11:9], a ^ b);
            endcase
         end
      end
      OP_LDR: begin
         exp_dm_addr  = addr;
         exp_dm_value = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
         commit_reg(insn[11:9], exp_dm_value);
      end
      OP_STR: begin
         exp_dm_we     = 1'b1;
         exp_dm_addr   = addr;
         exp_dm_value  = ref_regs[insn[11:9]];   // Data register in 11:9
         ref_mem[addr] = exp_dm_value;
      end
      OP_CONST: commit_reg(insn[11:9], {{7{insn[8]}}, insn[8:0]});
      default: begin
         exp_rf_we = 1'b0;   // Retires with no effect
      end
   endcase
   ref_pc = next_pc;
endtask

`endif

//--- sim/tb_lc4.sv
module tb_lc4
   import lc4_pkg::*;
();

   localparam word_t RESET_PC     = 16'h8200;
   localparam int    PROG_WORDS   = 200;
   localparam int    NUM_RETIRE   = 400;
   localparam int    RESET_CYCLES = 10;
   localparam int    MAX_CYCLES   = NUM_RETIRE * 5;   // 4 per retirement, rest for reset and fill

   logic     gwe;
   logic     reset;
   word_t    imem_addr, imem_data;
   word_t    dmem_addr, dmem_rdata, dmem_wdata;
   logic     dmem_we;
   logic     trace_valid, trace_rf_we, trace_nzp_we, trace_dm_we;
   word_t    trace_pc, trace_insn, trace_rf_data, trace_dm_addr, trace_dm_value;
   reg_idx_t trace_rf_reg;
   nzp_t     trace_nzp;

   word_t    prog [PROG_WORDS];
   word_t    dmem [word_t];
   int       errors  = 0;
   int       retired = 0;
   int       cycles  = 0;

   function automatic word_t fetch_word(input word_t addr);
      word_t idx;
      idx = addr - RESET_PC;
      if (idx < 16'(PROG_WORDS)) begin
         return prog[idx[7:0]];
      end
      return NOP_INSN;   // Past the program
   endfunction

   // Unwritten data words, every address bit counts
   function automatic word_t fill_word(input word_t addr);
      return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
   endfunction

   function automatic word_t read_dmem(input word_t addr);
      if (dmem.exists(addr)) begin
         return dmem[addr];
      end
      return fill_word(addr);
   endfunction

`include "lc4_isa_model.svh"

   lc4_processor #(
      .RESET_PC (RESET_PC)
   ) uut (
      .gwe                  (gwe),
      .i_reset              (reset),
      .o_imem_addr          (imem_addr),
      .i_imem_data          (imem_data),
      .o_dmem_addr          (dmem_addr),
      .i_dmem_data          (dmem_rdata),
      .o_dmem_wdata         (dmem_wdata),
      .o_dmem_we            (dmem_we),
      .o_trace_valid        (trace_valid),
      .o_trace_pc           (trace_pc),
      .o_trace_insn         (trace_insn),
      .o_trace_regfile_we   (trace_rf_we),
      .o_trace_regfile_reg  (trace_rf_reg),
      .o_trace_regfile_data (trace_rf_data),
      .o_trace_nzp_we       (trace_nzp_we),
      .o_trace_nzp          (trace_nzp),
      .o_trace_dmem_we      (trace_dm_we),
      .o_trace_dmem_addr    (trace_dm_addr),
      .o_trace_dmem_value   (trace_dm_value)
   );

   initial gwe = 1'b0;
   always #2 gwe = ~gwe;

   // **********************************************************************
   // Memories, both answer in the same cycle
   // **********************************************************************
   assign imem_data = fetch_word(imem_addr);

   // Re-read after a store, address may stay the same for a following load
   always_comb begin
      dmem_rdata = read_dmem(dmem_addr);
   end

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr] = dmem_wdata;   // Never a load in M this cycle
      end
   end

   // Random kept instructions, R6 and R7 hold memory bases
   task automatic build_program();
      logic [31:0] r;
      int          kind;
      reg_idx_t    rd, rs, rt, base;
      word_t       insn;
      prog[0] = {OP_CONST, 3'd6, 9'h040};
      prog[1] = {OP_CONST, 3'd7, 9'h0c0};
      for (int i = 2; i < PROG_WORDS; i++) begin
         r    = $urandom;
         kind = int'(r[3:0]);
         rd   = reg_idx_t'($urandom % 6);   // R0 to R5, dense dependences
         rs   = reg_idx_t'($urandom % 6);
         rt   = reg_idx_t'($urandom % 6);
         base = r[4] ? 3'd7 : 3'd6;
         case (kind)
            0, 1:    insn = {OP_BR, r[7:5], 6'd0, r[10:8]};   // Forward 0 to 7
            2, 3:    insn = {OP_ARITH, rd, rs, 3'b000, rt};
            4:       insn = {OP_ARITH, rd, rs, 1'b1, r[15:11]};
            5:       insn = {OP_LOGIC, rd, rs, 3'b000, rt};   // AND
            6:       insn = {OP_LOGIC, rd, rs, 3'b010, rt};   // OR
            7:       insn = {OP_LOGIC, rd, rs, 3'b011, rt};   // XOR
            8:       insn = {OP_LOGIC, rd, rs, 3'b001, rt};   // NOT
            9:       insn = {OP_LOGIC, rd, rs, 1'b1, r[15:11]};
            10, 11:  insn = {OP_CONST, rd, r[16:8]};
            12, 13:  insn = {OP_LDR, rd, base, {2{r[8]}}, r[8:5]};   // Offset -8 to 7
            default: insn = {OP_STR, rt, base, {2{r[8]}}, r[8:5]};
         endcase
         prog[i] = insn;
      end
   endtask

   task automatic check_value(input string field, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL t=%0t %s: got %h expected %h", $time, field, got, exp);
      end
   endtask

   // **********************************************************************
   // Trace compare, sampled away from the edge
   // **********************************************************************
   always @(negedge gwe) begin
      if (!reset && trace_valid && retired < NUM_RETIRE) begin
         execute_insn();
         if (retired == 0) begin
            check_value("first pc", trace_pc, RESET_PC);
         end
         check_value("pc", trace_pc, exp_pc);
         check_value("insn", trace_insn, exp_insn);
         check_value("regfile_we", word_t'(trace_rf_we), word_t'(exp_rf_we));
         check_value("regfile_reg", word_t'(trace_rf_reg), word_t'(exp_rf_reg));
         check_value("regfile_data", trace_rf_data, exp_rf_data);
         check_value("nzp_we", word_t'(trace_nzp_we), word_t'(exp_nzp_we));
         check_value("nzp", word_t'(trace_nzp), word_t'(exp_nzp));
         check_value("dmem_we", word_t'(trace_dm_we), word_t'(exp_dm_we));
         check_value("dmem_addr", trace_dm_addr, exp_dm_addr);
         check_value("dmem_value", trace_dm_value, exp_dm_value);
         retired++;
      end
   end

   always @(posedge gwe) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("Timeout after %0d cycles, only %0d of %0d instructions retired",
                  cycles, retired, NUM_RETIRE);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      reset = 1'b1;
      void'($urandom(23425));   // Fixed seed
      build_program();
      init_model();
      repeat (RESET_CYCLES) @(posedge gwe);
      reset <= 1'b0;
      while (retired < NUM_RETIRE) begin
         @(posedge gwe);
      end
      $display("Done: %0d mismatches over %0d retired instructions", errors, retired);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
